// ==== Bender.yml ====
package:
  name: zet_front

sources:
  - include_dirs:
      - src
    files:
      - src/zet_front_pkg.sv
      - src/zet_next_or_not.sv
      - src/zet_nstate.sv
      - src/zet_opcode_decode.sv
      - src/zet_ip_regs.sv
      - src/zet_fetch.sv
      - src/zet_front_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/zet_front_tb.sv

// ==== dv/zet_front_tb.sv ====
// front end testbench, memory answers the word at pc in the same cycle
// program runs from 0000:0000 with rep looping, then again at ff80:1000
// (wraps to 0x00800) with cx_zero set, so the rep string op is skipped

`timescale 1ns/1ns
`default_nettype none

`include "zet_front_defs.svh"

module zet_front_tb;

  import zet_front_pkg::*;

  localparam int PROG_LEN       = 18;
  localparam int TIMEOUT_CYCLES = PROG_LEN * 20;
  localparam logic [15:0] CS2   = 16'hFF80;
  localparam logic [15:0] IP2   = 16'h1000;

  logic        clk = 1'b0;
  logic        rst;
  logic [15:0] data;
  logic        block = 1'b0;
  logic        end_seq;
  logic        cx_zero;
  logic        zf;
  logic        load_cs_ip;
  logic [15:0] cs_in;
  logic [15:0] ip_in;
  logic [19:0] pc;
  logic        bytefetch;
  logic [7:0]  opcode;
  logic [7:0]  modrm;
  logic [15:0] off_l;
  logic [15:0] imm_l;
  logic        rep;
  sovr_t       sop_l;
  logic        exec_st;
  logic        ld_base;
  logic [15:0] ip;
  logic [15:0] ip0;

  logic [7:0]  mem [0:65535];  // 64 KB window of the 1 MB space
  logic [31:0] lfsr = 32'h855d;
  logic        stall_en = 1'b0;
  logic [15:0] cs_model;
  logic [19:0] pc_ref;
  logic [15:0] run_cs;

  // reference model results for the instruction being fetched
  logic [7:0]  exp_opcode;
  logic [7:0]  exp_modrm;
  logic [15:0] exp_off;
  logic [15:0] exp_imm;
  logic [15:0] exp_ip;
  logic [15:0] exp_start;
  logic        exp_rep;
  logic [2:0]  exp_sop;
  int          errors = 0;
  int          retired = 0;

  zet_front_top dut0 (
    .clk (clk), .rst (rst), .data (data), .block (block), .end_seq (end_seq),
    .cx_zero (cx_zero), .zf (zf), .load_cs_ip (load_cs_ip), .cs_in (cs_in),
    .ip_in (ip_in), .pc (pc), .bytefetch (bytefetch), .opcode (opcode),
    .modrm (modrm), .off_l (off_l), .imm_l (imm_l), .rep (rep), .sop_l (sop_l),
    .exec_st (exec_st), .ld_base (ld_base), .ip (ip), .ip0 (ip0)
  );

  initial
  begin
    forever #10 clk = ~clk;
  end

  assign data   = {mem[pc[15:0] + 16'd1], mem[pc[15:0]]};  // little endian
  assign pc_ref = 20'(cs_model * 32'd16 + ip);             // real mode, wraps at 1 MB

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [7:0] prog_byte(input int i);
    case (i)
      1:       return 8'h88;  // mov [bp+5],al
      2:       return 8'h46;
      3:       return 8'h05;
      4:       return 8'hB8;  // mov ax,1234h
      5:       return 8'h34;
      6:       return 8'h12;
      7:       return 8'h89;  // mov [5678h],ax
      8:       return 8'h06;
      9:       return 8'h78;
      10:      return 8'h56;
      11:      return 8'h2E;  // cs: mov al,[bx]
      12:      return 8'h8A;
      13:      return 8'h07;
      14:      return 8'hF3;  // rep movsb
      15:      return 8'hA4;
      default: return `ZET_OP_NOP;
    endcase
  endfunction

  function automatic logic is_prefix(input logic [7:0] b);
    return b inside {8'h26, 8'h2E, 8'h36, 8'h3E, 8'hF2, 8'hF3};
  endfunction

  function automatic logic [1:0] prefix_seg(input logic [7:0] b);
    case (b)
      8'h26:   return 2'd0;  // es
      8'h2E:   return 2'd1;  // cs
      8'h36:   return 2'd2;  // ss
      default: return 2'd3;  // ds
    endcase
  endfunction

  function automatic logic [7:0] code_byte(input logic [15:0] seg, input logic [15:0] off);
    logic [19:0] a;
    a = {seg, 4'h0} + {4'h0, off};
    return mem[a[15:0]];
  endfunction

  function automatic logic [15:0] code_word(input logic [15:0] seg, input logic [15:0] off);
    return {code_byte(seg, off + 16'd1), code_byte(seg, off)};
  endfunction

  task automatic report_mismatch(input string msg);
    errors = errors + 1;
    $display("mismatch at %0t: %s", $time, msg);
  endtask

  // walks one instruction, skipping a rep string op when cx is zero
  task automatic predict_instruction(input logic [15:0] seg, input logic [15:0] start,
                                     input logic cx);
    logic [15:0] p;
    logic [7:0]  b;
    logic        rep_seen;
    logic [2:0]  sop;
    logic        skipped;
    p = start;
    skipped = 1'b1;
    while (skipped)
    begin
      exp_start = p;
      rep_seen  = 1'b0;
      sop       = 3'b000;
      b = code_byte(seg, p);
      while (is_prefix(b))
      begin
        if (b == 8'hF2 || b == 8'hF3)
          rep_seen = 1'b1;
        else
          sop = {1'b1, prefix_seg(b)};
        p = p + 16'd1;
        b = code_byte(seg, p);
      end
      exp_opcode = b;
      exp_modrm  = 8'h00;
      exp_off    = 16'h0000;
      exp_imm    = 16'h0000;
      p = p + 16'd1;
      if (b >= 8'h88 && b <= 8'h8B)
      begin
        exp_modrm = code_byte(seg, p);
        p = p + 16'd1;
        if (exp_modrm[7:6] == 2'b01)
        begin
          exp_off = {8'h00, code_byte(seg, p)};
          p = p + 16'd1;
        end
        else if (exp_modrm[7:6] == 2'b10 || exp_modrm[7:6] == 2'b00 && exp_modrm[2:0] == 3'b110)
        begin
          exp_off = code_word(seg, p);
          p = p + 16'd2;
        end
      end
      else if ((b >= 8'hB0 && b <= 8'hB7) || b == 8'h04)
      begin
        exp_imm = {8'h00, code_byte(seg, p)};
        p = p + 16'd1;
      end
      else if (b >= 8'hB8 && b <= 8'hBF)
      begin
        exp_imm = code_word(seg, p);
        p = p + 16'd2;
      end
      exp_rep = rep_seen;
      exp_sop = sop;
      skipped = rep_seen && cx && (b == 8'hA4 || b == 8'hA5);
    end
    exp_ip = p;
  endtask

  // end_seq two cycles in, held until an unstalled edge takes it
  task end_instruction();
    repeat (2) @(posedge clk);
    end_seq <= 1'b1;
    do @(posedge clk); while (block);
    end_seq <= 1'b0;
  endtask

  task wait_exec();
    do @(posedge clk); while (!exec_st);
    retired = retired + 1;
  endtask

  always @(posedge clk)
  begin : stall_gen
    logic b0;
    logic b1;
    if (rst || !stall_en)
      block <= 1'b0;
    else
    begin
      b0 = lfsr[0];
      lfsr = lfsr_next(lfsr);
      b1 = lfsr[0];
      lfsr = lfsr_next(lfsr);
      block <= b0 & b1;  // stall about one cycle in four
    end
  end

  always @(posedge clk)
    if (rst)
      cs_model <= 16'h0000;
    else if (load_cs_ip)
      cs_model <= cs_in;

  a_reset_state: assert property (@(posedge clk)
    $fell(rst) |-> exec_st && opcode == `ZET_OP_NOP && !rep)
    else report_mismatch("state after reset");

  a_fields: assert property (@(posedge clk) disable iff (rst)
    $rose(exec_st) |-> opcode == exp_opcode && modrm == exp_modrm
                       && off_l == exp_off && imm_l == exp_imm)
    else report_mismatch($sformatf("fields %h %h %h %h, expected %h %h %h %h",
                         opcode, modrm, off_l, imm_l, exp_opcode, exp_modrm, exp_off, exp_imm));

  a_ip: assert property (@(posedge clk) disable iff (rst)
    $rose(exec_st) |-> ip == exp_ip && ip0 == exp_start)
    else report_mismatch($sformatf("ip %h ip0 %h, expected %h %h", ip, ip0, exp_ip, exp_start));

  a_pc: assert property (@(posedge clk) disable iff (rst) pc == pc_ref)
    else report_mismatch($sformatf("pc %h, expected %h", pc, pc_ref));

  a_load: assert property (@(posedge clk) disable iff (rst)
    load_cs_ip |=> ip == $past(ip_in) && pc == pc_ref)
    else report_mismatch("cs:ip after load");

  // each unstalled fetch cycle takes one byte, or two when bytefetch is low
  a_fetch_width: assert property (@(posedge clk) disable iff (rst)
    !exec_st && !block && !load_cs_ip
    |=> ip == $past(ip) + ($past(bytefetch) ? 16'd1 : 16'd2))
    else report_mismatch($sformatf("ip %h does not follow the bytefetch width", ip));

  a_ld_base: assert property (@(posedge clk) disable iff (rst)
    ld_base |=> exec_st)
    else report_mismatch("ld_base without entry to execution");

  a_exec_entry: assert property (@(posedge clk) disable iff (rst)
    $rose(exec_st) |-> $past(ld_base))
    else report_mismatch("execution entered without ld_base");

  a_prefix: assert property (@(posedge clk) disable iff (rst)
    $rose(exec_st) |-> sop_l == exp_sop && rep == exp_rep)
    else report_mismatch($sformatf("sop_l %b rep %b, expected %b %b",
                         sop_l, rep, exp_sop, exp_rep));

  a_rep_loop: assert property (@(posedge clk) disable iff (rst)
    exec_st && rep && end_seq && !block && !cx_zero |=> exec_st && $stable(ip))
    else report_mismatch("rep pass left execution or moved ip");

  a_rep_skip: assert property (@(posedge clk) disable iff (rst)
    $rose(exec_st) |-> !(cx_zero && rep && opcode inside {8'hA4, 8'hA5}))
    else report_mismatch("rep string op executed with cx zero");

  a_block_hold: assert property (@(posedge clk) disable iff (rst)
    block && !load_cs_ip |=> $stable(pc) && $stable(opcode) && $stable(off_l)
                             && $stable(imm_l) && $stable(exec_st))
    else report_mismatch("outputs moved under block");

  initial
  begin
    int n;
    for (n = 0; n < PROG_LEN; n = n + 1)
    begin
      mem[16'h0000 + n] = prog_byte(n);
      mem[16'h0800 + n] = prog_byte(n);  // ff80:1000 lands here
    end
    rst        = 1'b1;
    end_seq    = 1'b0;
    cx_zero    = 1'b0;
    zf         = 1'b0;
    load_cs_ip = 1'b0;
    cs_in      = 16'h0000;
    ip_in      = 16'h0000;
    run_cs     = 16'h0000;
    repeat (8) @(posedge clk);
    rst      <= 1'b0;
    stall_en <= 1'b1;
    predict_instruction(run_cs, 16'h0000, 1'b0);
    end_instruction();  // leaves the NOP held from reset
    for (n = 0; n < 6; n = n + 1)
    begin
      wait_exec();
      if (n < 5)
      begin
        predict_instruction(run_cs, exp_ip, 1'b0);
        end_instruction();
      end
    end
    repeat (3) end_instruction();  // rep movsb passes, cx not zero
    load_cs_ip <= 1'b1;
    cs_in      <= CS2;
    ip_in      <= IP2;
    cx_zero    <= 1'b1;
    @(posedge clk);
    load_cs_ip <= 1'b0;
    run_cs = CS2;
    predict_instruction(run_cs, IP2, 1'b1);
    end_instruction();  // rep stops, second pass begins
    for (n = 0; n < 6; n = n + 1)
    begin
      wait_exec();
      if (n < 5)
      begin
        predict_instruction(run_cs, exp_ip, 1'b1);
        end_instruction();
      end
    end
    repeat (3) @(posedge clk);
    $display("%0d instructions checked, %0d errors", retired, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: program did not finish in %0d cycles, %0d errors",
             TIMEOUT_CYCLES, errors);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/zet_fetch.sv ====
// fetch state machine: prefixes, opcode, modrm, offset, immediate
// each field is latched in its own register, byte fields zero-extended,
// word fields little-endian; data must be valid in the same cycle as pc
// block freezes state and every latch

`timescale 1ns/1ns
`default_nettype none

`include "zet_front_defs.svh"

module zet_fetch (
  input  wire                    clk,
  input  wire                    rst,
  input  wire [`ZET_WORD_W-1:0]  data,
  input  wire                    block,
  input  wire                    end_seq,
  input  wire                    cx_zero,
  input  wire                    zf,
  input  wire                    need_modrm,
  input  wire                    need_off,
  input  wire                    need_imm,
  input  wire                    off_size,
  input  wire                    imm_size,
  output logic [7:0]             opcode,
  output logic [7:0]             modrm,
  output logic [`ZET_WORD_W-1:0] off_l,
  output logic [`ZET_WORD_W-1:0] imm_l,
  output logic                   rep,
  output zet_front_pkg::sovr_t   sop_l,
  output logic                   exec_st,
  output logic                   ld_base,
  output logic                   bytefetch,
  output logic                   fetch_en,
  output logic [1:0]             imm_f,
  output logic                   wr_ip0
);

  import zet_front_pkg::*;

  fetch_state_t state;
  fetch_state_t next_state;
  pref_t        pref_l;
  logic [7:0]   opcode_l;
  logic [7:0]   modrm_l;
  logic         sovr_pr;
  logic         repz_pr;
  logic         prefix;
  logic         next_in_opco;
  logic         next_in_exec;

  zet_next_or_not u_next_or_not (
    .pref         (pref_l),
    .opbase       (opcode[7:1]),
    .cx_zero      (cx_zero),
    .zf           (zf),
    .next_in_opco (next_in_opco),
    .next_in_exec (next_in_exec)
  );

  zet_nstate u_nstate (
    .state        (state),
    .prefix       (prefix),
    .need_modrm   (need_modrm),
    .need_off     (need_off),
    .need_imm     (need_imm),
    .end_seq      (end_seq),
    .next_in_opco (next_in_opco),
    .next_in_exec (next_in_exec),
    .block        (block),
    .next_state   (next_state)
  );

  // live byte while its field is on the bus
  assign opcode = (state == opcod_st) ? data[7:0] : opcode_l;
  assign modrm  = (state == modrm_st) ? data[7:0] : modrm_l;

  assign sovr_pr = (opcode[7:5] == 3'b001) && (opcode[2:0] == 3'b110);  // 26 2E 36 3E
  assign repz_pr = (opcode[7:1] == 7'b1111_001);                        // F2 F3
  assign prefix  = sovr_pr | repz_pr;

  assign exec_st   = (state == execu_st);
  assign fetch_en  = (state != execu_st);
  assign bytefetch = (state == offse_st) ? ~off_size : (state == immed_st) ? ~imm_size : 1'b1;
  assign imm_f     = ((state == offse_st && off_size) || (state == immed_st && imm_size))
                     ? 2'd2 : 2'd1;
  assign wr_ip0    = (state == opcod_st) && !pref_l.rep && !sop_l.ovr;
  assign rep       = pref_l.rep;

  // entering execu_st, also a new rep pass
  assign ld_base = (next_state == execu_st) && !block && (state != execu_st || end_seq);

  always_ff @(posedge clk)
    if (rst)
    begin
      state    <= execu_st;
      opcode_l <= `ZET_OP_NOP;
      modrm_l  <= '0;
      off_l    <= '0;
      imm_l    <= '0;
      pref_l   <= '0;
      sop_l    <= '0;
    end
    else if (!block)
    begin
      state <= next_state;
      case (state)
        opcod_st:
          if (prefix)
          begin
            if (repz_pr) pref_l <= '{rep: 1'b1, zf_sense: opcode[0]};
            if (sovr_pr) sop_l  <= '{ovr: 1'b1, seg: opcode[4:3]};
          end
          else if (next_state == opcod_st)
          begin
            pref_l <= '0;  // rep string op skipped on cx zero
            sop_l  <= '0;
          end
          else
            opcode_l <= data[7:0];
        modrm_st: modrm_l <= data[7:0];
        offse_st: off_l <= off_size ? data : {8'h00, data[7:0]};
        immed_st: imm_l <= imm_size ? data : {8'h00, data[7:0]};
        execu_st:
          if (next_state == opcod_st)
          begin
            // new instruction starts clean
            pref_l  <= '0;
            sop_l   <= '0;
            modrm_l <= '0;
            off_l   <= '0;
            imm_l   <= '0;
          end
        default: ;
      endcase
    end

  a_block_holds: assert property (@(posedge clk) disable iff (rst)
    block |=> $stable({state, opcode_l, modrm_l, off_l, imm_l, pref_l, sop_l}));

endmodule

`default_nettype wire

// ==== src/zet_front_defs.svh ====
// widths and fixed opcodes for the instruction front end
// ZET_ADDR_W must be ZET_WORD_W + 4 (real mode segment shift)
// the opcode held after reset is a plain one byte instruction

`ifndef ZET_FRONT_DEFS_SVH
`define ZET_FRONT_DEFS_SVH

// physical address bus
`define ZET_ADDR_W 20

// data, ip and cs width
`define ZET_WORD_W 16

`define ZET_OP_NOP 8'h90  // xchg ax,ax

`endif

// ==== src/zet_front_pkg.sv ====
// types shared by the fetch machine, its next-state logic and the top level
// state encodings are fixed; execu_st is the reset state

`default_nettype none

package zet_front_pkg;

  typedef enum logic [2:0] {
    opcod_st = 3'd0,
    modrm_st = 3'd1,
    offse_st = 3'd2,
    immed_st = 3'd3,
    execu_st = 3'd4
  } fetch_state_t;

  // repeat prefix, zf_sense is bit 0 of F2/F3
  typedef struct packed {
    logic rep;
    logic zf_sense;
  } pref_t;

  typedef struct packed {
    logic       ovr;  // segment override seen
    logic [1:0] seg;  // es cs ss ds
  } sovr_t;

endpackage

`default_nettype wire

// ==== src/zet_front_top.sv ====
// instruction front end: fetch machine, length decoder and cs:ip registers
// memory returns the little-endian word at pc in the same cycle
// end_seq comes from the execution sequencer outside

`timescale 1ns/1ns
`default_nettype none

`include "zet_front_defs.svh"

module zet_front_top (
  input  wire                    clk,
  input  wire                    rst,
  input  wire [`ZET_WORD_W-1:0]  data,
  input  wire                    block,
  input  wire                    end_seq,
  input  wire                    cx_zero,
  input  wire                    zf,
  input  wire                    load_cs_ip,
  input  wire [`ZET_WORD_W-1:0]  cs_in,
  input  wire [`ZET_WORD_W-1:0]  ip_in,
  output logic [`ZET_ADDR_W-1:0] pc,
  output logic                   bytefetch,
  output logic [7:0]             opcode,
  output logic [7:0]             modrm,
  output logic [`ZET_WORD_W-1:0] off_l,
  output logic [`ZET_WORD_W-1:0] imm_l,
  output logic                   rep,
  output zet_front_pkg::sovr_t   sop_l,
  output logic                   exec_st,
  output logic                   ld_base,
  output logic [`ZET_WORD_W-1:0] ip,
  output logic [`ZET_WORD_W-1:0] ip0
);

  logic                   need_modrm;
  logic                   need_off;
  logic                   need_imm;
  logic                   off_size;
  logic                   imm_size;
  logic                   fetch_en;
  logic [1:0]             imm_f;
  logic                   wr_ip0;

  zet_fetch u_fetch (
    .clk (clk), .rst (rst), .data (data), .block (block), .end_seq (end_seq),
    .cx_zero (cx_zero), .zf (zf), .need_modrm (need_modrm), .need_off (need_off),
    .need_imm (need_imm), .off_size (off_size), .imm_size (imm_size),
    .opcode (opcode), .modrm (modrm), .off_l (off_l), .imm_l (imm_l), .rep (rep),
    .sop_l (sop_l), .exec_st (exec_st), .ld_base (ld_base), .bytefetch (bytefetch),
    .fetch_en (fetch_en), .imm_f (imm_f), .wr_ip0 (wr_ip0)
  );

  zet_opcode_decode u_decode (
    .opcode (opcode), .modrm (modrm), .need_modrm (need_modrm), .need_off (need_off),
    .need_imm (need_imm), .off_size (off_size), .imm_size (imm_size)
  );

  zet_ip_regs u_ip_regs (
    .clk (clk), .rst (rst), .load_cs_ip (load_cs_ip), .cs_in (cs_in), .ip_in (ip_in),
    .fetch_en (fetch_en), .imm_f (imm_f), .block (block), .wr_ip0 (wr_ip0),
    .cs (), .ip (ip), .ip0 (ip0), .pc (pc)
  );

endmodule

`default_nettype wire

// ==== src/zet_ip_regs.sv ====
// cs:ip registers and the real mode physical address
// load_cs_ip wins over the ip advance; pc wraps at 1 MB
// ip0 is the start of the instruction, prefixes included

`timescale 1ns/1ns
`default_nettype none

`include "zet_front_defs.svh"

module zet_ip_regs (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    load_cs_ip,
  input  wire [`ZET_WORD_W-1:0]  cs_in,
  input  wire [`ZET_WORD_W-1:0]  ip_in,
  input  wire                    fetch_en,
  input  wire [1:0]              imm_f,     // bytes taken this cycle
  input  wire                    block,
  input  wire                    wr_ip0,
  output logic [`ZET_WORD_W-1:0] cs,
  output logic [`ZET_WORD_W-1:0] ip,
  output logic [`ZET_WORD_W-1:0] ip0,
  output logic [`ZET_ADDR_W-1:0] pc
);

  always_ff @(posedge clk)
    if (rst)
    begin
      cs <= '0;
      ip <= '0;
    end
    else if (load_cs_ip)
    begin
      cs <= cs_in;
      ip <= ip_in;
    end
    else if (fetch_en && !block)
      ip <= ip + {{(`ZET_WORD_W-2){1'b0}}, imm_f};

  always_ff @(posedge clk)
    if (wr_ip0 && !block)
      ip0 <= ip;  // first byte of the instruction

  assign pc = {cs, 4'h0} + {4'h0, ip};  // mod 2^20

  a_imm_f_range: assert property (@(posedge clk) disable iff (rst)
                                  fetch_en |-> imm_f inside {2'd1, 2'd2});

endmodule

`default_nettype wire

// ==== src/zet_next_or_not.sv ====
// repeat decision for string instructions under F2/F3
// covers movs, cmps, stos, lods, scas; ins/outs are not handled
// pure combinational, evaluated on the live or latched opcode

`timescale 1ns/1ns
`default_nettype none

module zet_next_or_not (
  input  wire zet_front_pkg::pref_t pref,
  input  wire [6:0]                 opbase,   // opcode[7:1]
  input  wire                       cx_zero,
  input  wire                       zf,
  output logic                      next_in_opco,
  output logic                      next_in_exec
);

  logic string_op;
  logic cmp_sca;
  logic exit_z;
  logic exit_rep;

  // A4..AF, except the test opcodes A8/A9
  assign string_op = (opbase[6:3] == 4'b1010) && (opbase[2:1] != 2'b00)
                     && (opbase[2:0] != 3'b100);

  // cmps A6/A7 and scas AE/AF are the only ones that look at zf
  assign cmp_sca = opbase[1] & opbase[0];

  // repe stops on zf clear, repne stops on zf set
  assign exit_z   = cmp_sca & (pref.zf_sense ? ~zf : zf);
  assign exit_rep = cx_zero | exit_z;

  assign next_in_exec = pref.rep & string_op & ~exit_rep;  // run another pass
  assign next_in_opco = pref.rep & string_op & cx_zero;    // skip it, no pass at all

endmodule

`default_nettype wire

// ==== src/zet_nstate.sv ====
// next fetch state, one field per unstalled cycle
// prefixes loop in opcod_st; execu_st is left only on end_seq
// block holds the current state

`timescale 1ns/1ns
`default_nettype none

module zet_nstate (
  input  wire zet_front_pkg::fetch_state_t state,
  input  wire                              prefix,
  input  wire                              need_modrm,
  input  wire                              need_off,
  input  wire                              need_imm,
  input  wire                              end_seq,
  input  wire                              next_in_opco,
  input  wire                              next_in_exec,
  input  wire                              block,
  output zet_front_pkg::fetch_state_t      next_state
);

  import zet_front_pkg::*;

  always_comb
  begin
    next_state = state;
    if (!block)
      case (state)
        opcod_st:
          if (prefix || next_in_opco)
            next_state = opcod_st;  // more prefixes, or a skipped rep string op
          else if (need_modrm) next_state = modrm_st;
          else if (need_off)   next_state = offse_st;
          else if (need_imm)   next_state = immed_st;
          else                 next_state = execu_st;
        modrm_st:
          if (need_off)      next_state = offse_st;
          else if (need_imm) next_state = immed_st;
          else               next_state = execu_st;
        offse_st: next_state = need_imm ? immed_st : execu_st;
        immed_st: next_state = execu_st;
        execu_st:
          if (end_seq)
            next_state = next_in_exec ? execu_st : opcod_st;  // rep loops without a fetch
        default: next_state = execu_st;
      endcase
  end

  // state register lives in zet_fetch
  a_state_legal: assert final ($isunknown(state)
                               || state inside {opcod_st, modrm_st, offse_st, immed_st, execu_st});

endmodule

`default_nettype wire

// ==== src/zet_opcode_decode.sv ====
// length decoder for a reduced opcode map
// knows mov r/m (88-8B), byte immediates (B0-B7, 04) and word immediates
// (B8-BF); every other opcode is treated as a one byte instruction

`timescale 1ns/1ns
`default_nettype none

module zet_opcode_decode (
  input  wire [7:0] opcode,
  input  wire [7:0] modrm,
  output logic      need_modrm,
  output logic      need_off,
  output logic      need_imm,
  output logic      off_size,   // 1: off16
  output logic      imm_size    // 1: imm16
);

  localparam logic [1:0] MOD_MEM   = 2'b00;
  localparam logic [1:0] MOD_DISP8 = 2'b01;
  localparam logic [1:0] MOD_DISP16 = 2'b10;
  localparam logic [2:0] RM_DIRECT = 3'b110;

  always_comb
  begin
    need_modrm = 1'b0;
    need_imm   = 1'b0;
    imm_size   = 1'b0;
    if (opcode[7:2] == 6'b1000_10)
      need_modrm = 1'b1;  // 88-8B
    else if (opcode[7:3] == 5'b1011_0 || opcode == 8'h04)
      need_imm = 1'b1;
    else if (opcode[7:3] == 5'b1011_1)
    begin
      need_imm = 1'b1;
      imm_size = 1'b1;
    end
  end

  // displacement only exists behind a modrm byte here
  always_comb
  begin
    need_off = 1'b0;
    off_size = 1'b0;
    if (need_modrm)
      case (modrm[7:6])
        MOD_MEM:
          if (modrm[2:0] == RM_DIRECT)
          begin
            need_off = 1'b1;  // direct address
            off_size = 1'b1;
          end
        MOD_DISP8:  need_off = 1'b1;
        MOD_DISP16:
        begin
          need_off = 1'b1;
          off_size = 1'b1;
        end
        default: ;  // register operand
      endcase
  end

endmodule

`default_nettype wire

// ==== zet_front.f ====
+incdir+src
src/zet_front_pkg.sv
src/zet_next_or_not.sv
src/zet_nstate.sv
src/zet_opcode_decode.sv
src/zet_ip_regs.sv
src/zet_fetch.sv
src/zet_front_top.sv
dv/zet_front_tb.sv
